//--- rtl/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int ADDR_W   = 32;   // fetch address width
    localparam int INDEX_W  = 6;    // 64 sets
    localparam int OFFSET_W = 6;    // 64-byte line
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 20 bits
    localparam int LINE_W   = 512;
    localparam int FETCH_W  = 64;   // two instructions per fetch
    localparam int WAYS     = 2;
    localparam int SETS     = 1 << INDEX_W;

    // burst length codes, n means n+1 beats on the bus
    localparam logic [7:0] RLEN_LINE     = 8'd15;
    localparam logic [7:0] RLEN_UNCACHED = 8'd1;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [FETCH_W-1:0] fetch_t;

    // valid flag sits above the tag, 21 bits in all
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

endpackage

//--- rtl/icache_sram.sv
`timescale 1ns/1ps

module icache_sram
    import icache_pkg::*;
#(
    parameter type entry_t     = tagv_t,
    parameter bit  RESET_CLEAR = 1'b0   // clear every entry while rstn is low
) (
    input  logic   clk,
    input  logic   rstn,
    input  index_t i_raddr,
    input  index_t i_waddr,
    input  logic   i_we,
    input  entry_t i_wdata,
    output entry_t o_rdata
);

    entry_t mem [SETS];

    always_ff @(posedge clk) begin
        if (RESET_CLEAR && !rstn) begin
            for (int i = 0; i < SETS; i++) begin
                mem[i] <= '0;   // valid flags start low
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, data one cycle after the index
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

//--- rtl/icache_lru.sv
`timescale 1ns/1ps

module icache_lru
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  index_t i_index,
    input  logic   i_update,
    input  logic   i_used_way,
    output logic   o_victim_way
);

    // one bit per set, names the most recently used way
    logic [SETS-1:0] mru;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru <= '0;
        end else if (i_update) begin
            mru[i_index] <= i_used_way;
        end
    end

    // with two ways the victim is simply the other one
    assign o_victim_way = ~mru[i_index];

endmodule

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // pipeline request
    input  logic       i_req_valid,
    input  addr_t      i_req_addr,
    input  logic       i_uncache,
    output logic       o_req_ready,
    // hit info from the top
    input  logic       i_hit,
    input  logic       i_hit_way,
    input  logic       i_victim_way,
    // memory side
    input  logic       i_mem_rready,
    input  line_t      i_mem_rdata,
    output logic       o_mem_rvalid,
    output addr_t      o_mem_raddr,
    output logic [7:0] o_mem_rlen,
    // array control
    output index_t     o_rd_index,
    output index_t     o_wr_index,
    output logic [1:0] o_tag_we,
    output logic [1:0] o_data_we,
    output tagv_t      o_wr_tagv,
    output line_t      o_wr_line,
    // lru update
    output logic       o_lru_update,
    output logic       o_lru_way,
    // response
    output logic       o_resp_valid,
    output logic       o_from_refill,
    output line_t      o_refill_line,
    output addr_t      o_req_buf,
    output logic       o_uncache_buf
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } state_t;

    state_t state;
    state_t next_state;

    addr_t  req_buf;        // address of the request in flight
    logic   uncache_buf;
    line_t  ret_buf;        // line (or uncached beat) back from memory

    logic   lookup_hit;
    logic   accept;
    logic   refill_write;
    logic   mem_done;

    // uncached lookups always go to memory, even if the line is resident
    assign lookup_hit   = (state == LOOKUP) && i_hit && !uncache_buf;
    assign o_req_ready  = (state == IDLE) || lookup_hit;
    assign accept       = i_req_valid && o_req_ready;
    assign mem_done     = o_mem_rvalid && i_mem_rready;
    assign refill_write = (state == REFILL) && !uncache_buf;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_req_valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!lookup_hit) begin
                    next_state = MISS;
                end else if (!i_req_valid) begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                next_state = IDLE;  // arrays settle before the next read
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= i_req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            uncache_buf <= 1'b0;
        end else if (accept) begin
            uncache_buf <= i_uncache;
        end
    end

    // return buffer
    always_ff @(posedge clk) begin
        if (mem_done) begin
            ret_buf <= i_mem_rdata;
        end
    end

    assign o_rd_index = accept ? i_req_addr[OFFSET_W +: INDEX_W] : req_buf[OFFSET_W +: INDEX_W];
    assign o_wr_index = req_buf[OFFSET_W +: INDEX_W];

    // memory request held steady for the whole miss state
    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = uncache_buf ? {req_buf[ADDR_W-1:3], 3'b000}
                                      : {req_buf[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign o_mem_rlen   = uncache_buf ? RLEN_UNCACHED : RLEN_LINE;

    // refill goes into the victim way
    assign o_tag_we  = refill_write ? (i_victim_way ? 2'b10 : 2'b01) : 2'b00;
    assign o_data_we = o_tag_we;

    assign o_wr_tagv.valid = 1'b1;
    assign o_wr_tagv.tag   = req_buf[ADDR_W-1 -: TAG_W];
    assign o_wr_line       = ret_buf;

    assign o_lru_update = lookup_hit || refill_write;
    assign o_lru_way    = lookup_hit ? i_hit_way : i_victim_way;

    assign o_resp_valid  = lookup_hit || (state == REFILL);
    assign o_from_refill = (state == REFILL);
    assign o_refill_line = ret_buf;
    assign o_req_buf     = req_buf;
    assign o_uncache_buf = uncache_buf;

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    // pipeline
    input  logic       i_req_valid,
    input  addr_t      i_req_addr,
    input  logic       i_uncache,
    output logic       o_req_ready,
    output logic       o_resp_valid,
    output fetch_t     o_resp_data,
    output addr_t      o_resp_addr,
    // memory
    output logic       o_mem_rvalid,
    output addr_t      o_mem_raddr,
    output logic [7:0] o_mem_rlen,
    input  logic       i_mem_rready,
    input  line_t      i_mem_rdata
);

    index_t     rd_index;
    index_t     wr_index;
    logic [1:0] tag_we;
    logic [1:0] data_we;
    tagv_t      wr_tagv;
    line_t      wr_line;

    tagv_t      tag_rdata [WAYS];
    line_t      line_rdata [WAYS];

    logic [1:0] hit;
    logic       cache_hit;
    logic       hit_way;
    logic       victim_way;
    logic       lru_update;
    logic       lru_way;

    logic       from_refill;
    line_t      refill_line;
    addr_t      req_buf;
    logic       uncache_buf;

    tag_t       req_tag;
    line_t      line_sel;
    fetch_t     word_sel;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_sram #(
            .entry_t     (tagv_t),
            .RESET_CLEAR (1'b1)
        ) u_tagv (
            .clk     (clk),
            .rstn    (rstn),
            .i_raddr (rd_index),
            .i_waddr (wr_index),
            .i_we    (tag_we[w]),
            .i_wdata (wr_tagv),
            .o_rdata (tag_rdata[w])
        );

        icache_sram #(
            .entry_t (line_t)
        ) u_data (
            .clk     (clk),
            .rstn    (rstn),
            .i_raddr (rd_index),
            .i_waddr (wr_index),
            .i_we    (data_we[w]),
            .i_wdata (wr_line),
            .o_rdata (line_rdata[w])
        );

        assign hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_tag);
    end

    assign req_tag   = req_buf[ADDR_W-1 -: TAG_W];
    assign cache_hit = |hit;
    assign hit_way   = ~hit[0];     // way 0 wins, only meaningful on a hit

    icache_lru u_lru (
        .clk          (clk),
        .rstn         (rstn),
        .i_index      (wr_index),
        .i_update     (lru_update),
        .i_used_way   (lru_way),
        .o_victim_way (victim_way)
    );

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_req_valid   (i_req_valid),
        .i_req_addr    (i_req_addr),
        .i_uncache     (i_uncache),
        .o_req_ready   (o_req_ready),
        .i_hit         (cache_hit),
        .i_hit_way     (hit_way),
        .i_victim_way  (victim_way),
        .i_mem_rready  (i_mem_rready),
        .i_mem_rdata   (i_mem_rdata),
        .o_mem_rvalid  (o_mem_rvalid),
        .o_mem_raddr   (o_mem_raddr),
        .o_mem_rlen    (o_mem_rlen),
        .o_rd_index    (rd_index),
        .o_wr_index    (wr_index),
        .o_tag_we      (tag_we),
        .o_data_we     (data_we),
        .o_wr_tagv     (wr_tagv),
        .o_wr_line     (wr_line),
        .o_lru_update  (lru_update),
        .o_lru_way     (lru_way),
        .o_resp_valid  (o_resp_valid),
        .o_from_refill (from_refill),
        .o_refill_line (refill_line),
        .o_req_buf     (req_buf),
        .o_uncache_buf (uncache_buf)
    );

    // after a refill the arrays are stale for this request, use the return buffer
    assign line_sel = from_refill ? refill_line : line_rdata[hit_way];
    assign word_sel = line_sel[req_buf[OFFSET_W-1:3] * FETCH_W +: FETCH_W];

    // uncached beat lands in the low bits
    assign o_resp_data = uncache_buf ? refill_line[FETCH_W-1:0] : word_sel;
    assign o_resp_addr = req_buf;

endmodule

//--- tests/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model
    import icache_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h85fc_807c
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       i_mem_rvalid,
    input  addr_t      i_mem_raddr,
    input  logic [7:0] i_mem_rlen,
    output logic       o_mem_rready,
    output line_t      o_mem_rdata
);

    localparam fetch_t DATA_KEY = 64'h5a5a_c3c3_0ff0_9669;

    integer      seed;
    logic        busy;
    int          wait_left;
    logic [31:0] rnd;

    // each 64-bit word is its own byte address mixed with a key
    function automatic fetch_t word_at(input addr_t a);
        return {32'h0, a[ADDR_W-1:3], 3'b000} ^ DATA_KEY;
    endfunction

    function automatic line_t build_line(input addr_t a);
        line_t line;
        for (int i = 0; i < LINE_W / FETCH_W; i++) begin
            line[i*FETCH_W +: FETCH_W] = word_at({a[ADDR_W-1:OFFSET_W], 3'(i), 3'b000});
        end
        return line;
    endfunction

    // uncached beat in the low word, the rest is filler
    function automatic line_t build_beat(input addr_t a);
        line_t beat;
        beat = '1;
        beat[FETCH_W-1:0] = word_at(a);
        return beat;
    endfunction

    initial begin
        seed         = SEED;
        busy         = 1'b0;
        wait_left    = 0;
        o_mem_rready = 1'b0;
        o_mem_rdata  = '0;
        forever begin
            @(negedge clk);
            o_mem_rready = 1'b0;    // rready is a one-cycle pulse
            if (!rstn) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_left == 0) begin
                    o_mem_rready = 1'b1;
                    if (i_mem_rlen == RLEN_UNCACHED) begin
                        o_mem_rdata = build_beat(i_mem_raddr);
                    end else begin
                        o_mem_rdata = build_line(i_mem_raddr);
                    end
                    busy = 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end else if (i_mem_rvalid) begin
                rnd       = $random(seed);
                wait_left = int'(rnd % 6);  // pulse comes 1 to 6 cycles later
                busy      = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_icache.sv
`timescale 1ns/1ps

module tb_icache
    import icache_pkg::*;
();

    localparam int          NUM_REQ    = 2000;
    localparam int          MAX_CYCLES = NUM_REQ * 10;   // a miss takes about ten cycles at most
    localparam fetch_t      DATA_KEY   = 64'h5a5a_c3c3_0ff0_9669;
    localparam logic [17:0] TAG_LOW    = 18'h2_a5c3;

    logic       clk = 1'b0;
    logic       rstn;
    logic       req_valid;
    addr_t      req_addr;
    logic       uncache;
    logic       req_ready;
    logic       resp_valid;
    fetch_t     resp_data;
    addr_t      resp_addr;
    logic       mem_rvalid;
    addr_t      mem_raddr;
    logic [7:0] mem_rlen;
    logic       mem_rready;
    line_t      mem_rdata;

    integer seed;
    int     cycle_count = 0;
    int     resp_count = 0;
    int     issued = 0;
    int     mem_cycle = 0;
    logic   mem_seen = 1'b0;
    logic   req_taken = 1'b0;

    // fetches accepted but not yet answered, oldest first
    addr_t  pend_addr[$];
    logic   pend_unc[$];
    logic   pend_hit[$];
    int     pend_cycle[$];

    // reference tag/valid and lru tables
    tag_t   m_tag [WAYS][SETS];
    logic   m_valid [WAYS][SETS];
    logic   m_mru [SETS];

    always #20 clk = ~clk;

    icache u_dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (req_valid),
        .i_req_addr   (req_addr),
        .i_uncache    (uncache),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_data  (resp_data),
        .o_resp_addr  (resp_addr),
        .o_mem_rvalid (mem_rvalid),
        .o_mem_raddr  (mem_raddr),
        .o_mem_rlen   (mem_rlen),
        .i_mem_rready (mem_rready),
        .i_mem_rdata  (mem_rdata)
    );

    icache_mem_model #(
        .SEED (32'h85fc_807c)
    ) u_mem (
        .clk          (clk),
        .rstn         (rstn),
        .i_mem_rvalid (mem_rvalid),
        .i_mem_raddr  (mem_raddr),
        .i_mem_rlen   (mem_rlen),
        .o_mem_rready (mem_rready),
        .o_mem_rdata  (mem_rdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_fetch(input string name, input fetch_t got, input fetch_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_rlen(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    // memory content is the 8-byte address mixed with a key
    function automatic fetch_t expected_word(input addr_t a);
        return {32'h0, a[ADDR_W-1:3], 3'b000} ^ DATA_KEY;
    endfunction

    // applies one fetch to the tables, returns whether it hits
    function automatic logic model_lookup(input addr_t a, input logic unc);
        index_t set;
        tag_t   tg;
        logic   hit;
        logic   way;
        set = a[OFFSET_W +: INDEX_W];
        tg  = a[ADDR_W-1 -: TAG_W];
        hit = 1'b0;
        way = 1'b0;
        if (unc) begin
            return 1'b0;    // no allocation, no lru change
        end
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[w][set] && m_tag[w][set] == tg) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            way = !m_mru[set];  // refill replaces the least recently used way
            m_valid[way][set] = 1'b1;
            m_tag[way][set]   = tg;
        end
        m_mru[set] = way;
        return hit;
    endfunction

    task automatic random_request();
        logic [31:0] r;
        logic [1:0]  tsel;
        r    = $random(seed);
        tsel = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];   // three tags, the first twice as often
        if (r[14:11] == 4'd0) begin
            req_valid = 1'b0;
        end else begin
            req_valid = 1'b1;
            req_addr  = {tsel, TAG_LOW, r[3:2], 4'b0101, r[6:4], r[7], 2'b00};
            uncache   = (r[10:8] == 3'd0);
            issued++;
        end
    endtask

    always @(posedge clk) begin
        addr_t head_addr;
        logic  head_hit;
        int    head_cycle;
        logic  exp_ready;
        logic  exp_rvalid;
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d responses",
                                cycle_count, resp_count, NUM_REQ));
        end
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[0][s] = 1'b0;
                m_valid[1][s] = 1'b0;
                m_mru[s]      = 1'b0;
            end
            req_taken = 1'b0;
        end else begin
            req_taken = req_valid && req_ready;
            // ready only when idle or in a hit lookup
            exp_ready  = 1'b1;
            exp_rvalid = 1'b0;
            if (pend_addr.size() != 0) begin
                exp_ready  = pend_hit[0];
                // memory asked from the cycle after a missed lookup until it answers
                exp_rvalid = !pend_hit[0] && !mem_seen && cycle_count >= pend_cycle[0] + 2;
            end
            check_flag("o_req_ready", req_ready, exp_ready);
            check_flag("o_mem_rvalid", mem_rvalid, exp_rvalid);
            if (mem_rvalid && mem_rready) begin
                head_addr = pend_addr[0];
                if (pend_unc[0]) begin
                    check_addr("o_mem_raddr", mem_raddr, {head_addr[ADDR_W-1:3], 3'b000});
                    check_rlen("o_mem_rlen", mem_rlen, RLEN_UNCACHED);
                end else begin
                    check_addr("o_mem_raddr", mem_raddr,
                               {head_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
                    check_rlen("o_mem_rlen", mem_rlen, RLEN_LINE);
                end
                mem_seen  = 1'b1;
                mem_cycle = cycle_count;
            end
            if (resp_valid) begin
                if (pend_addr.size() == 0) begin
                    abort_run("response with no fetch outstanding");
                end else begin
                    head_addr  = pend_addr.pop_front();
                    head_hit   = pend_hit.pop_front();
                    head_cycle = pend_cycle.pop_front();
                    void'(pend_unc.pop_front());
                    check_addr("o_resp_addr", resp_addr, head_addr);
                    check_fetch("o_resp_data", resp_data, expected_word(head_addr));
                    if (head_hit && cycle_count != head_cycle + 1) begin
                        abort_run("hit response did not come in the cycle after acceptance");
                    end
                    if (!head_hit && !(mem_seen && cycle_count == mem_cycle + 1)) begin
                        abort_run("miss response did not follow the memory return");
                    end
                    mem_seen = 1'b0;
                    resp_count++;
                end
            end
            if (req_taken) begin
                pend_addr.push_back(req_addr);
                pend_unc.push_back(uncache);
                pend_hit.push_back(model_lookup(req_addr, uncache));
                pend_cycle.push_back(cycle_count);
            end
        end
    end

    initial begin
        seed      = 32'h85fc_807c;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        uncache   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (!req_ready || resp_valid || mem_rvalid) begin
            abort_run("cache outputs not idle after reset");
        end
        while (issued < NUM_REQ) begin
            @(negedge clk);
            if (!req_valid || req_taken) begin
                random_request();
            end
        end
        @(negedge clk);
        while (!req_taken) begin
            @(negedge clk);
        end
        req_valid = 1'b0;
        while (resp_count < NUM_REQ) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // room for a stray response
        $display("Regression passed");
        $finish;
    end

endmodule

//--- icache.f
rtl/icache_pkg.sv
rtl/icache_sram.sv
rtl/icache_lru.sv
rtl/icache_ctrl.sv
rtl/icache.sv
tests/icache_mem_model.sv
tests/tb_icache.sv

//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_icache -f icache.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_icache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
